//--- flist.f
+incdir+include
source/conv_accel_pkg.sv
source/conv_input_seq.sv
source/conv_core.sv
source/conv_output_stage.sv
source/conv_accel_top.sv
verif/conv_accel_tb.sv

//--- include/conv_accel_config.svh
`ifndef CONV_ACCEL_CONFIG_SVH
`define CONV_ACCEL_CONFIG_SVH

// pixels carried side by side in one beat
`define CONV_UNITS 4

// conv cores, one weight word each per beat
`define CONV_CORES 4

// signed input and output word
`define CONV_WORD_WIDTH 8

// signed accumulator, headroom for long channel groups
`define CONV_ACC_WIDTH 20

// leaky relu alpha as a plain shift, 1/8
`define CONV_LRELU_SHIFT 3

// requantize back toward word range
`define CONV_OUT_SHIFT 4

`endif

//--- source/conv_accel_pkg.sv
`default_nettype none

`include "conv_accel_config.svh"

package conv_accel_pkg;

  // single signed data word
  typedef logic signed [`CONV_WORD_WIDTH-1:0] word_t;

  // single signed accumulator
  typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

  // one pixel beat, unit 0 in the low bits
  typedef word_t [`CONV_UNITS-1:0] pixel_vec_t;

  // one weight beat, core 0 in the low bits
  typedef word_t [`CONV_CORES-1:0] weight_vec_t;

  // sums of one core, one per unit
  typedef acc_t [`CONV_UNITS-1:0] acc_vec_t;

  // activation picked per group from pixel tuser
  typedef enum logic {
    act_none,
    act_lrelu
  } act_e;

  // broadcast to every core
  typedef struct packed {
    // capture products from stage 0
    logic mul_en;
    // fold products into accumulators
    logic acc_en;
    // first channel of a group, load instead of add
    logic acc_first;
  } core_ctrl_t;

  // flags that ride along with a beat through the pipeline
  typedef struct packed {
    logic valid;
    logic last;
    logic first;
    act_e act;
  } beat_tag_t;

  // output stage fsm
  typedef enum logic {
    out_idle,
    out_send
  } out_state_e;

endpackage

`default_nettype wire

//--- source/conv_accel_top.sv
`default_nettype none

`include "conv_accel_config.svh"

module conv_accel_top (
  input  logic                        aclk,
  input  logic                        rst_n,
  // pixel stream
  input  logic                        s_pix_tvalid,
  output logic                        s_pix_tready,
  input  conv_accel_pkg::pixel_vec_t  s_pix_tdata,
  input  logic                        s_pix_tlast,
  // is_lrelu for the group
  input  logic                        s_pix_tuser,
  // weight stream
  input  logic                        s_wgt_tvalid,
  output logic                        s_wgt_tready,
  input  conv_accel_pkg::weight_vec_t s_wgt_tdata,
  input  logic                        s_wgt_tlast,
  // output stream, one beat per core
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output conv_accel_pkg::pixel_vec_t  m_tdata,
  output logic                        m_tlast
);

  // sequencer to cores
  conv_accel_pkg::core_ctrl_t  core_ctrl;
  conv_accel_pkg::pixel_vec_t  pix_q;
  conv_accel_pkg::weight_vec_t wgt_q;
  // sequencer and output stage
  logic                        result_strobe;
  conv_accel_pkg::act_e        result_act;
  logic                        buffer_free;
  // cores to output stage
  conv_accel_pkg::acc_vec_t    core_sums [`CONV_CORES];

  conv_input_seq i_conv_input_seq (
    .aclk          (aclk         ),
    .rst_n         (rst_n        ),
    .s_pix_tvalid  (s_pix_tvalid ),
    .s_pix_tready  (s_pix_tready ),
    .s_pix_tdata   (s_pix_tdata  ),
    .s_pix_tlast   (s_pix_tlast  ),
    .s_pix_tuser   (s_pix_tuser  ),
    .s_wgt_tvalid  (s_wgt_tvalid ),
    .s_wgt_tready  (s_wgt_tready ),
    .s_wgt_tdata   (s_wgt_tdata  ),
    .s_wgt_tlast   (s_wgt_tlast  ),
    .buffer_free   (buffer_free  ),
    .core_ctrl     (core_ctrl    ),
    .pix_q         (pix_q        ),
    .wgt_q         (wgt_q        ),
    .result_strobe (result_strobe),
    .result_act    (result_act   )
  );

  // same pixels to all cores, each with its own weight word
  generate
    for (genvar c = 0; c < `CONV_CORES; c++) begin : g_core
      conv_core i_conv_core (
        .aclk      (aclk        ),
        .rst_n     (rst_n       ),
        .core_ctrl (core_ctrl   ),
        .pix       (pix_q       ),
        .wgt       (wgt_q[c]    ),
        .sums      (core_sums[c])
      );
    end
  endgenerate

  conv_output_stage i_conv_output_stage (
    .aclk          (aclk         ),
    .rst_n         (rst_n        ),
    .result_strobe (result_strobe),
    .result_act    (result_act   ),
    .core_sums     (core_sums    ),
    .buffer_free   (buffer_free  ),
    .m_tvalid      (m_tvalid     ),
    .m_tready      (m_tready     ),
    .m_tdata       (m_tdata      ),
    .m_tlast       (m_tlast      )
  );

endmodule

`default_nettype wire

//--- source/conv_core.sv
`default_nettype none

`include "conv_accel_config.svh"

module conv_core (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  conv_accel_pkg::core_ctrl_t core_ctrl,
  input  conv_accel_pkg::pixel_vec_t pix,
  input  conv_accel_pkg::word_t      wgt,
  output conv_accel_pkg::acc_vec_t   sums
);

  localparam int UNITS = `CONV_UNITS;

  // stage 1 products, one per unit
  conv_accel_pkg::acc_vec_t prod_q;
  // stage 2 running sums
  conv_accel_pkg::acc_vec_t acc_q;
  // products captured and not yet folded in
  logic prod_fresh;

  // signed multiply, operands extend to accumulator width
  always_ff @(posedge aclk) begin
    if (core_ctrl.mul_en) begin
      for (int u = 0; u < UNITS; u++) begin
        prod_q[u] <= pix[u] * wgt;
      end
    end
  end

  // load on first channel, add on the rest
  always_ff @(posedge aclk) begin
    if (core_ctrl.acc_en) begin
      for (int u = 0; u < UNITS; u++) begin
        if (core_ctrl.acc_first) begin
          acc_q[u] <= prod_q[u];
        end else begin
          acc_q[u] <= acc_q[u] + prod_q[u];
        end
      end
    end
  end

  // product bookkeeping across pipeline freezes
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      prod_fresh <= 1'b0;
    end else if (core_ctrl.mul_en) begin
      prod_fresh <= 1'b1;
    end else if (core_ctrl.acc_en) begin
      prod_fresh <= 1'b0;
    end
  end

  assign sums = acc_q;

  // sequencer must never accumulate stale or missing products
  a_acc_after_mul : assert property (
    @(posedge aclk) disable iff (!rst_n)
    core_ctrl.acc_en |-> prod_fresh
  ) else $error("accumulate without products captured first");

endmodule

`default_nettype wire

//--- source/conv_input_seq.sv
`default_nettype none

module conv_input_seq (
  input  logic                        aclk,
  input  logic                        rst_n,
  // pixel stream
  input  logic                        s_pix_tvalid,
  output logic                        s_pix_tready,
  input  conv_accel_pkg::pixel_vec_t  s_pix_tdata,
  input  logic                        s_pix_tlast,
  input  logic                        s_pix_tuser,
  // weight stream
  input  logic                        s_wgt_tvalid,
  output logic                        s_wgt_tready,
  input  conv_accel_pkg::weight_vec_t s_wgt_tdata,
  input  logic                        s_wgt_tlast,
  // from output stage
  input  logic                        buffer_free,
  // to the cores
  output conv_accel_pkg::core_ctrl_t  core_ctrl,
  output conv_accel_pkg::pixel_vec_t  pix_q,
  output conv_accel_pkg::weight_vec_t wgt_q,
  // to output stage
  output logic                        result_strobe,
  output conv_accel_pkg::act_e        result_act
);

  // pipeline moves as one block
  logic advance;
  // joined pixel and weight handshake
  logic accept;
  // group final beat leaving stage 1 this cycle
  logic group_done;
  // next accepted beat opens a new group
  logic first_q;

  // stage 0 is the input register, stage 1 the product register
  conv_accel_pkg::beat_tag_t s0_tag;
  conv_accel_pkg::beat_tag_t s1_tag;

  // freeze only when a finished group has nowhere to go
  assign advance = !(s1_tag.valid && s1_tag.last && !buffer_free);

  // each ready waits for the other stream, so a lone valid never transfers
  assign s_pix_tready = s_wgt_tvalid && advance;
  assign s_wgt_tready = s_pix_tvalid && advance;
  assign accept       = s_pix_tvalid && s_wgt_tvalid && advance;

  assign group_done = advance && s1_tag.valid && s1_tag.last;

  // stage 0 payload, held while frozen
  always_ff @(posedge aclk) begin
    if (accept) begin
      pix_q <= s_pix_tdata;
      wgt_q <= s_wgt_tdata;
    end
  end

  // group boundary tracking
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;
    end else if (accept) begin
      // beat after a tlast starts the next group
      first_q <= s_pix_tlast;
    end
  end

  // beat flags down the stages
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      s0_tag <= '0;
      s1_tag <= '0;
    end else if (advance) begin
      // bubble enters stage 0 when no pair is joined
      s0_tag.valid <= accept;
      s0_tag.last  <= s_pix_tlast;
      s0_tag.first <= first_q;
      // group activation taken from the tlast beat
      s0_tag.act   <= s_pix_tuser ? conv_accel_pkg::act_lrelu : conv_accel_pkg::act_none;
      s1_tag       <= s0_tag;
    end
  end

  // stage 2 result flag, lines up with the finished accumulators
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      result_strobe <= 1'b0;
      result_act    <= conv_accel_pkg::act_none;
    end else begin
      result_strobe <= group_done;
      if (group_done) begin
        result_act <= s1_tag.act;
      end
    end
  end

  // core controls straight from the stage flags
  always_comb begin
    core_ctrl           = '0;
    // stage 0 to product register
    core_ctrl.mul_en    = s0_tag.valid && advance;
    // product register to accumulator
    core_ctrl.acc_en    = s1_tag.valid && advance;
    // new group loads fresh
    core_ctrl.acc_first = s1_tag.valid && s1_tag.first;
  end

  // both streams must agree on where a group ends
  a_tlast_match : assert property (
    @(posedge aclk) disable iff (!rst_n)
    accept |-> (s_pix_tlast == s_wgt_tlast)
  ) else $error("pixel and weight tlast differ on an accepted beat");

endmodule

`default_nettype wire

//--- source/conv_output_stage.sv
`default_nettype none

`include "conv_accel_config.svh"

module conv_output_stage (
  input  logic                       aclk,
  input  logic                       rst_n,
  // finished group from the sequencer
  input  logic                       result_strobe,
  input  conv_accel_pkg::act_e       result_act,
  input  conv_accel_pkg::acc_vec_t   core_sums [`CONV_CORES],
  // back to the sequencer
  output logic                       buffer_free,
  // output stream
  output logic                       m_tvalid,
  input  logic                       m_tready,
  output conv_accel_pkg::pixel_vec_t m_tdata,
  output logic                       m_tlast
);

  localparam int CORES    = `CONV_CORES;
  localparam int UNITS    = `CONV_UNITS;
  localparam int IDX_W    = (CORES > 1) ? $clog2(CORES) : 1;
  localparam int LAST_IDX = CORES - 1;

  // saturation bounds of an output word
  localparam conv_accel_pkg::acc_t SAT_MAX = (1 <<< (`CONV_WORD_WIDTH - 1)) - 1;
  localparam conv_accel_pkg::acc_t SAT_MIN = -(1 <<< (`CONV_WORD_WIDTH - 1));

  conv_accel_pkg::out_state_e state;
  // core being sent, 0 first
  logic [IDX_W-1:0]           core_idx;
  // activation of the buffered group
  conv_accel_pkg::act_e       act_q;
  // one group of sums from all cores
  conv_accel_pkg::acc_vec_t   sum_buf [CORES];

  // leaky relu, requantize, saturate
  function automatic conv_accel_pkg::word_t requant(
    input conv_accel_pkg::acc_t sum,
    input conv_accel_pkg::act_e act
  );
    conv_accel_pkg::acc_t v;
    v = sum;
    // negative side scaled by alpha
    if (act == conv_accel_pkg::act_lrelu && v < 0) begin
      v = v >>> `CONV_LRELU_SHIFT;
    end
    v = v >>> `CONV_OUT_SHIFT;
    // clamp into word range
    if (v > SAT_MAX) begin
      v = SAT_MAX;
    end else if (v < SAT_MIN) begin
      v = SAT_MIN;
    end
    return v[`CONV_WORD_WIDTH-1:0];
  endfunction

  // grab every core at once so the cores can start the next group
  always_ff @(posedge aclk) begin
    if (state == conv_accel_pkg::out_idle && result_strobe) begin
      sum_buf <= core_sums;
    end
  end

  // step through the cores, one beat per handshake
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= conv_accel_pkg::out_idle;
      core_idx <= '0;
      act_q    <= conv_accel_pkg::act_none;
    end else begin
      case (state)
        conv_accel_pkg::out_idle: begin
          if (result_strobe) begin
            state    <= conv_accel_pkg::out_send;
            core_idx <= '0;
            act_q    <= result_act;
          end
        end
        conv_accel_pkg::out_send: begin
          if (m_tready) begin
            if (core_idx == IDX_W'(LAST_IDX)) begin
              // whole group out, buffer free again
              state    <= conv_accel_pkg::out_idle;
              core_idx <= '0;
            end else begin
              core_idx <= core_idx + 1'b1;
            end
          end
        end
        default: begin
          state <= conv_accel_pkg::out_idle;
        end
      endcase
    end
  end

  // stream side and the free level
  always_comb begin
    m_tvalid    = (state == conv_accel_pkg::out_send);
    m_tlast     = m_tvalid && (core_idx == IDX_W'(LAST_IDX));
    // strobe in flight counts as occupied
    buffer_free = (state == conv_accel_pkg::out_idle) && !result_strobe;
    // data follows the buffer and index, so it holds under back-pressure
    for (int u = 0; u < UNITS; u++) begin
      m_tdata[u] = requant(sum_buf[core_idx][u], act_q);
    end
  end

  // axi-stream rule on the output
  a_m_hold : assert property (
    @(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
  ) else $error("m stream changed while stalled");

  // sequencer freeze must keep a second group from landing on a full buffer
  a_no_overrun : assert property (
    @(posedge aclk) disable iff (!rst_n)
    result_strobe |-> state == conv_accel_pkg::out_idle
  ) else $error("result strobe while output buffer busy");

endmodule

`default_nettype wire

//--- verif/conv_accel_tb.sv
`default_nettype none

`include "conv_accel_config.svh"

module conv_accel_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // 4 single, 6 multi-beat, 3 saturating, 20 under random back-pressure
  localparam int NUM_GROUPS     = 33;
  localparam int TIMEOUT_CYCLES = NUM_GROUPS * 40 + 200;
  localparam int MAX_BEATS      = 6;

  logic                        aclk;
  logic                        rst_n;
  logic                        s_pix_tvalid;
  logic                        s_pix_tready;
  conv_accel_pkg::pixel_vec_t  s_pix_tdata;
  logic                        s_pix_tlast;
  logic                        s_pix_tuser;
  logic                        s_wgt_tvalid;
  logic                        s_wgt_tready;
  conv_accel_pkg::weight_vec_t s_wgt_tdata;
  logic                        s_wgt_tlast;
  logic                        m_tvalid;
  logic                        m_tready;
  conv_accel_pkg::pixel_vec_t  m_tdata;
  logic                        m_tlast;

  integer seed;
  integer ready_seed;
  int     cycles;
  int     mismatches;
  int     errors;
  // quiet window right after reset
  logic   idle_phase;
  // random m_tready on or off
  logic   rand_ready;

  // expected output beats, front is the next one to leave
  conv_accel_pkg::pixel_vec_t exp_data_q [$];
  logic                       exp_last_q [$];
  // registered queue head, seen by the assertions
  logic                       exp_avail;
  conv_accel_pkg::pixel_vec_t exp_data;
  logic                       exp_last;

  conv_accel_top i_conv_accel_top (
    .aclk         (aclk        ),
    .rst_n        (rst_n       ),
    .s_pix_tvalid (s_pix_tvalid),
    .s_pix_tready (s_pix_tready),
    .s_pix_tdata  (s_pix_tdata ),
    .s_pix_tlast  (s_pix_tlast ),
    .s_pix_tuser  (s_pix_tuser ),
    .s_wgt_tvalid (s_wgt_tvalid),
    .s_wgt_tready (s_wgt_tready),
    .s_wgt_tdata  (s_wgt_tdata ),
    .s_wgt_tlast  (s_wgt_tlast ),
    .m_tvalid     (m_tvalid    ),
    .m_tready     (m_tready    ),
    .m_tdata      (m_tdata     ),
    .m_tlast      (m_tlast     )
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // division rounding toward minus infinity, same as an arithmetic shift
  function automatic int floor_div(input int n, input int d);
    if (n >= 0) begin
      return n / d;
    end
    return -((-n + d - 1) / d);
  endfunction

  // expected output word from a group sum
  function automatic conv_accel_pkg::word_t expect_word(input int sum, input logic lrelu);
    int v;
    v = sum;
    // alpha of 1/8 on the negative side
    if (lrelu && v < 0) begin
      v = floor_div(v, 1 << `CONV_LRELU_SHIFT);
    end
    v = floor_div(v, 1 << `CONV_OUT_SHIFT);
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    return conv_accel_pkg::word_t'(v);
  endfunction

  // narrow range keeps most results clear of saturation
  function automatic conv_accel_pkg::word_t rand_word(input logic narrow);
    integer r;
    r = $random(seed);
    if (narrow) begin
      return conv_accel_pkg::word_t'(r % 32);
    end
    return r[7:0];
  endfunction

  // one joined beat, entered and left at a falling edge
  task automatic drive_beat(
    input conv_accel_pkg::pixel_vec_t  pix,
    input conv_accel_pkg::weight_vec_t wgt,
    input logic                        last,
    input logic                        lrelu,
    input int                          skew
  );
    s_pix_tdata  = pix;
    s_pix_tlast  = last;
    s_pix_tuser  = lrelu;
    s_pix_tvalid = 1'b1;
    s_wgt_tdata  = wgt;
    s_wgt_tlast  = last;
    // pixel alone first, must not be taken
    s_wgt_tvalid = (skew == 0);
    for (int k = 0; k < skew; k++) begin
      @(negedge aclk);
    end
    s_wgt_tvalid = 1'b1;
    do begin
      @(posedge aclk);
    end while (!s_pix_tready);
    @(negedge aclk);
    s_pix_tvalid = 1'b0;
    s_wgt_tvalid = 1'b0;
    s_pix_tlast  = 1'b0;
    s_wgt_tlast  = 1'b0;
  endtask

  // mode 0 random, 1 positive overflow, 2 negative overflow
  task automatic send_group(
    input int   beats,
    input logic lrelu,
    input int   mode,
    input logic narrow,
    input logic skewed
  );
    conv_accel_pkg::pixel_vec_t  pix_mem [MAX_BEATS];
    conv_accel_pkg::weight_vec_t wgt_mem [MAX_BEATS];
    conv_accel_pkg::pixel_vec_t  exp_beat;
    int                          sum;
    int                          skew;
    for (int b = 0; b < beats; b++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        pix_mem[b][u] = (mode == 0) ? rand_word(narrow) : 8'sd127;
      end
      for (int c = 0; c < `CONV_CORES; c++) begin
        if (mode == 0) begin
          wgt_mem[b][c] = rand_word(narrow);
        end else begin
          wgt_mem[b][c] = (mode == 1) ? 8'sd127 : -8'sd128;
        end
      end
    end
    // expected beats go in before the group is driven
    for (int c = 0; c < `CONV_CORES; c++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        sum = 0;
        for (int b = 0; b < beats; b++) begin
          sum += int'(pix_mem[b][u]) * int'(wgt_mem[b][c]);
        end
        exp_beat[u] = expect_word(sum, lrelu);
      end
      exp_data_q.push_back(exp_beat);
      exp_last_q.push_back(c == `CONV_CORES - 1);
    end
    for (int b = 0; b < beats; b++) begin
      skew = skewed ? ($random(seed) & 3) : 0;
      drive_beat(pix_mem[b], wgt_mem[b], b == beats - 1, lrelu, skew);
    end
  endtask

  // pop on each output handshake, head registered for the next edge
  always @(posedge aclk) begin
    if (rst_n && m_tvalid && m_tready && exp_data_q.size() > 0) begin
      void'(exp_data_q.pop_front());
      void'(exp_last_q.pop_front());
    end
    if (exp_data_q.size() > 0) begin
      exp_avail <= 1'b1;
      exp_data  <= exp_data_q[0];
      exp_last  <= exp_last_q[0];
    end else begin
      exp_avail <= 1'b0;
    end
  end

  // m_tready pattern
  initial begin
    m_tready = 1'b1;
    forever begin
      @(negedge aclk);
      m_tready = rand_ready ? (($random(ready_seed) % 4) != 0) : 1'b1;
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d output beats never arrived",
               cycles, exp_data_q.size());
      $display("** FAIL **");
      $finish;
    end
  end

  a_out_data : assert property (
    @(posedge aclk) disable iff (!rst_n)
    m_tvalid && m_tready && exp_avail |-> m_tdata == exp_data
  ) else begin
    mismatches++;
    $display("MISMATCH at %0t: m_tdata %h, expected %h", $time, $sampled(m_tdata),
             $sampled(exp_data));
  end

  a_out_last : assert property (
    @(posedge aclk) disable iff (!rst_n)
    m_tvalid && m_tready && exp_avail |-> m_tlast == exp_last
  ) else begin
    mismatches++;
    $display("MISMATCH at %0t: m_tlast %b, expected %b", $time, $sampled(m_tlast),
             $sampled(exp_last));
  end

  // a beat with nothing expected means a duplicate or stray
  a_no_extra : assert property (
    @(posedge aclk) disable iff (!rst_n)
    m_tvalid && m_tready |-> exp_avail
  ) else begin
    errors++;
    $display("output beat at %0t with no beat expected", $time);
  end

  a_hold_stalled : assert property (
    @(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
  ) else begin
    errors++;
    $display("output beat changed or dropped while stalled at %0t", $time);
  end

  a_quiet_idle : assert property (
    @(posedge aclk) disable iff (!rst_n)
    idle_phase |-> !m_tvalid && !s_pix_tready && !s_wgt_tready
  ) else begin
    errors++;
    $display("valid or ready high with no input after reset at %0t", $time);
  end

  a_lone_pixel : assert property (
    @(posedge aclk) disable iff (!rst_n)
    s_pix_tvalid && !s_wgt_tvalid |-> !s_pix_tready
  ) else begin
    errors++;
    $display("pixel beat ready without a weight beat at %0t", $time);
  end

  // both streams transfer together once both offer a beat
  a_ready_pair : assert property (
    @(posedge aclk) disable iff (!rst_n)
    s_pix_tvalid && s_wgt_tvalid |-> s_wgt_tready == s_pix_tready
  ) else begin
    errors++;
    $display("weight ready and pixel ready differ on a joined beat at %0t", $time);
  end

  initial begin
    seed         = 97;
    ready_seed   = 97;
    cycles       = 0;
    mismatches   = 0;
    errors       = 0;
    idle_phase   = 1'b0;
    rand_ready   = 1'b0;
    exp_avail    = 1'b0;
    exp_data     = '0;
    exp_last     = 1'b0;
    rst_n        = 1'b0;
    s_pix_tvalid = 1'b0;
    s_pix_tdata  = '0;
    s_pix_tlast  = 1'b0;
    s_pix_tuser  = 1'b0;
    s_wgt_tvalid = 1'b0;
    s_wgt_tdata  = '0;
    s_wgt_tlast  = 1'b0;
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    rst_n      = 1'b1;
    idle_phase = 1'b1;
    repeat (10) @(negedge aclk);
    idle_phase = 1'b0;
    // single beat groups, plain requantize
    for (int g = 0; g < 4; g++) begin
      send_group(1, 1'b0, 0, g[0], 1'b0);
    end
    // accumulate over channels, back to back groups
    for (int g = 0; g < 6; g++) begin
      send_group(2 + (g % 5), $random(seed) & 1, 0, 1'b1, 1'b0);
    end
    // saturation at both ends, then leaky relu on a huge negative
    send_group(MAX_BEATS, 1'b0, 1, 1'b0, 1'b0);
    send_group(MAX_BEATS, 1'b0, 2, 1'b0, 1'b0);
    send_group(MAX_BEATS, 1'b1, 2, 1'b0, 1'b0);
    // output back-pressure and skewed input valids
    rand_ready = 1'b1;
    for (int g = 0; g < 20; g++) begin
      send_group(1 + (($random(seed) & 32'h7fff) % MAX_BEATS), $random(seed) & 1, 0,
                 $random(seed) & 1, 1'b1);
    end
    // drain
    while (exp_data_q.size() > 0 || m_tvalid) begin
      @(posedge aclk);
    end
    repeat (5) @(posedge aclk);
    $display("run complete: %0d mismatches, %0d other errors", mismatches, errors);
    if (mismatches + errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
